// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module routerTb -f src.f
	@out="$$(./obj_dir/VrouterTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod  = 5,
    parameter int resetCycles = 5
)(
    output logic clk,
    output logic rstN
);

    // Free-running clock, 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Low for the first few edges, released just after an edge
    initial
    begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

// File: crossbarSwitch.sv
`timescale 1ns/1ps

module crossbarSwitch (
    input  logic                                           clk,
    input  logic                                           rstN,
    portRequestIf.source                                   srcs [0:routerPkg::portCount-1],
    input  routerPkg::portSelT [routerPkg::portCount-1:0]  outSel,
    output logic [routerPkg::portCount-1:0]                outValid,
    output routerPkg::flitT [routerPkg::portCount-1:0]     outFlit
);

    // Head flit of every input
    routerPkg::flitT srcFlit [0:routerPkg::portCount-1];
    // Selected flit per output, before the register
    routerPkg::flitT muxFlit [0:routerPkg::portCount-1];

    for (genvar i = 0; i < routerPkg::portCount; i++)
    begin : gSrc
        assign srcFlit[i] = srcs[i].flit;
    end

    //////////////////////////////////////////////////
    // One-hot mux per output
    //////////////////////////////////////////////////

    // Select is one-hot or zero, so at most one input matches
    always_comb
    begin
        for (int o = 0; o < routerPkg::portCount; o++)
        begin
            muxFlit[o] = '0;
            for (int i = 0; i < routerPkg::portCount; i++)
            begin
                if (outSel[o][i])
                    muxFlit[o] = srcFlit[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////

    // Strobe is high for one cycle per delivered flit
    always_ff @(posedge clk)
    begin
        if (!rstN)
            outValid <= '0;
        else
        begin
            for (int o = 0; o < routerPkg::portCount; o++)
                outValid[o] <= |outSel[o];
        end
    end

    // Payload holds its last value while the output is idle
    always_ff @(posedge clk)
    begin
        for (int o = 0; o < routerPkg::portCount; o++)
        begin
            if (|outSel[o])
                outFlit[o] <= muxFlit[o];
        end
    end

endmodule

// File: flitFifo.sv
`timescale 1ns/1ps

module flitFifo #(
    parameter int fifoDepth = 4
)(
    input  logic            clk,
    input  logic            rstN,
    input  logic            wrEn,
    input  routerPkg::flitT wrFlit,
    input  logic            rdEn,
    output routerPkg::flitT headFlit,
    output logic            headValid,
    output logic            full
);

    // Keep at least one pointer bit for depth 1
    localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam int cntWidth = $clog2(fifoDepth + 1);

    // Flit storage
    routerPkg::flitT mem [0:fifoDepth-1];

    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;

    logic wrDo;
    logic rdDo;

    // Wraparound step for any depth
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
        return (p == ptrWidth'(fifoDepth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign headValid = (count != '0);
    assign full      = (count == cntWidth'(fifoDepth));
    assign headFlit  = mem[rdPtr];

    // Pop only a real head
    assign rdDo = rdEn & headValid;
    // Full buffer still takes a write when it drains the same cycle
    assign wrDo = wrEn & (~full | rdDo);

    always_ff @(posedge clk)
    begin
        if (wrDo)
        begin
            mem[wrPtr] <= wrFlit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (wrDo)
                wrPtr <= nextPtr(wrPtr);
            if (rdDo)
                rdPtr <= nextPtr(rdPtr);
            // Occupancy moves only on an unmatched push or pop
            case ({wrDo, rdDo})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: inputPort.sv
`timescale 1ns/1ps

module inputPort #(
    parameter int routerX   = 3,
    parameter int routerY   = 0,
    parameter int fifoDepth = 4
)(
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  routerPkg::flitT   inFlit,
    output logic              full,
    portRequestIf.requester   req
);

    // This node's position, trimmed to coordinate width
    localparam logic [routerPkg::coordWidth-1:0] myX =
        routerX[routerPkg::coordWidth-1:0];
    localparam logic [routerPkg::coordWidth-1:0] myY =
        routerY[routerPkg::coordWidth-1:0];

    routerPkg::flitT    headFlit;
    logic               headValid;
    routerPkg::portSelT routeSel;

    //////////////////////////////////////////////////
    // Flit buffer
    //////////////////////////////////////////////////

    // Popped on the edge that ends a granted cycle
    flitFifo #(
        .fifoDepth (fifoDepth)
    ) fifo0 (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (inValid),
        .wrFlit    (inFlit),
        .rdEn      (req.grant),
        .headFlit  (headFlit),
        .headValid (headValid),
        .full      (full)
    );

    //////////////////////////////////////////////////
    // Route computation
    //////////////////////////////////////////////////

    // Dimension order, X first then Y
    always_comb
    begin
        routeSel = '0;
        if (headFlit.destX > myX)
            routeSel[routerPkg::eastPort] = 1'b1;
        else if (headFlit.destX < myX)
            routeSel[routerPkg::westPort] = 1'b1;
        else if (headFlit.destY > myY)
            routeSel[routerPkg::northPort] = 1'b1;
        else if (headFlit.destY < myY)
            routeSel[routerPkg::southPort] = 1'b1;
        else
            routeSel[routerPkg::localPort] = 1'b1;
    end

    // Request follows the head, no register in between
    assign req.reqValid = headValid;
    // Empty buffer head is stale, keep the request word clean
    assign req.reqPort  = headValid ? routeSel : '0;
    assign req.flit     = headFlit;

endmodule

// File: meshRouter.sv
`timescale 1ns/1ps

module meshRouter #(
    parameter int routerX   = 3,
    parameter int routerY   = 0,
    parameter int fifoDepth = 4
)(
    input  logic                                         clk,
    input  logic                                         rstN,
    // Flit strobes from the neighbours and the local core
    input  logic [routerPkg::portCount-1:0]              inValid,
    input  routerPkg::flitT [routerPkg::portCount-1:0]   inFlit,
    // Sender must hold off while high
    output logic [routerPkg::portCount-1:0]              inFull,
    // Registered crossbar outputs
    output logic [routerPkg::portCount-1:0]              outValid,
    output routerPkg::flitT [routerPkg::portCount-1:0]   outFlit
);

    //////////////////////////////////////////////////
    // Internal links
    //////////////////////////////////////////////////

    // One request bundle per input
    portRequestIf reqBus [0:routerPkg::portCount-1] ();

    // Allocator to crossbar, one select word per output
    routerPkg::portSelT [routerPkg::portCount-1:0] outSel;

    //////////////////////////////////////////////////
    // Input ports
    //////////////////////////////////////////////////

    // Index g is both the physical input and its bus
    for (genvar g = 0; g < routerPkg::portCount; g++)
    begin : gInput
        inputPort #(
            .routerX   (routerX),
            .routerY   (routerY),
            .fifoDepth (fifoDepth)
        ) inPort (
            .clk     (clk),
            .rstN    (rstN),
            .inValid (inValid[g]),
            .inFlit  (inFlit[g]),
            .full    (inFull[g]),
            .req     (reqBus[g])
        );
    end

    //////////////////////////////////////////////////
    // Switch allocation
    //////////////////////////////////////////////////

    // Grants go back on the same buses
    switchAllocator alloc0 (
        .clk    (clk),
        .rstN   (rstN),
        .reqs   (reqBus),
        .outSel (outSel)
    );

    //////////////////////////////////////////////////
    // Switch traversal
    //////////////////////////////////////////////////

    // Registers the granted heads on the popping edge
    crossbarSwitch xbar0 (
        .clk      (clk),
        .rstN     (rstN),
        .srcs     (reqBus),
        .outSel   (outSel),
        .outValid (outValid),
        .outFlit  (outFlit)
    );

endmodule

// File: meshRouter_checker.sv
`timescale 1ns/1ps

module meshRouter_checker (
    input  logic                                           clk,
    input  logic                                           rstN,
    input  logic [routerPkg::portCount-1:0]                inValid,
    input  logic [routerPkg::portCount-1:0]                inFull,
    input  logic [routerPkg::portCount-1:0]                outValid,
    input  routerPkg::portSelT [routerPkg::portCount-1:0]  outSel,
    input  logic [routerPkg::portCount-1:0]                reqValid,
    input  logic [routerPkg::portCount-1:0]                grant
);

    // Number of failed assertions so far
    int failCount = 0;

    //////////////////////////////////////////////////
    // Allocator to crossbar
    //////////////////////////////////////////////////

    // One winner per output, or none
    for (genvar o = 0; o < routerPkg::portCount; o++)
    begin : gSel
        selOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(outSel[o]))
        else
        begin
            failCount++;
            $error("select word of output %0d has more than one bit set", o);
        end
    end

    // Grant only on a live request
    grantHasReq: assert property (@(posedge clk) disable iff (!rstN) (grant & ~reqValid) == '0)
    else
    begin
        failCount++;
        $error("grant given to an input with no request");
    end

    //////////////////////////////////////////////////
    // Link strobes
    //////////////////////////////////////////////////

    validKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(outValid))
    else
    begin
        failCount++;
        $error("outValid is unknown");
    end

    // A write into a full buffer is lost unless the head leaves that cycle
    noDrop: assert property (@(posedge clk) disable iff (!rstN) (inValid & inFull & ~grant) == '0)
    else
    begin
        failCount++;
        $error("flit written while inFull was high and nothing drained");
    end

endmodule

// File: portRequestIf.sv
`timescale 1ns/1ps

interface portRequestIf;

    // Head flit present, held while the buffer is non-empty
    logic                reqValid;
    // One-hot target output from route computation
    routerPkg::portSelT  reqPort;
    // Head flit itself
    routerPkg::flitT     flit;
    // Single-cycle win pulse from the allocator
    logic                grant;

    // Input side
    modport requester
    (
        output reqValid,
        output reqPort,
        output flit,
        input  grant
    );

    // Allocator side
    modport arbiter
    (
        input  reqValid,
        input  reqPort,
        output grant
    );

    // Crossbar only looks at the payload
    modport source
    (
        input  flit
    );

endinterface

// File: routerPkg.sv
package routerPkg;

    //////////////////////////////////////////////////
    // Port numbering
    //////////////////////////////////////////////////

    // Local plus four mesh directions
    localparam int portCount = 5;

    // Same index names an input and an output
    localparam int localPort = 0;
    localparam int northPort = 1;
    localparam int eastPort  = 2;
    localparam int southPort = 3;
    localparam int westPort  = 4;

    //////////////////////////////////////////////////
    // Flit format
    //////////////////////////////////////////////////

    // One mesh coordinate, up to 8 by 8 nodes
    localparam int coordWidth = 3;

    // Payload byte
    localparam int dataWidth = 8;

    // Single-flit packet
    // Destination first, payload in the low bits
    typedef struct packed
    {
        logic [coordWidth-1:0] destX;
        logic [coordWidth-1:0] destY;
        logic [dataWidth-1:0]  data;
    } flitT;

    //////////////////////////////////////////////////
    // Select words
    //////////////////////////////////////////////////

    // One-hot over the ports
    // Target output in a request, source input in a crossbar select
    // All zero means nothing selected
    typedef logic [portCount-1:0] portSelT;

endpackage

// File: routerTb.sv
`timescale 1ns/1ps

module routerTb;

    localparam int nodeX       = 3;
    localparam int nodeY       = 2;
    localparam int ports       = routerPkg::portCount;
    localparam int localP      = routerPkg::localPort;
    localparam int burstLength = 12;
    // Rough summed run length of all tests in cycles
    localparam int testCycles  = 20 + 3 * ports + 10 + 12 + (ports - 1) * burstLength + 20;
    // Fourfold margin over the summed length
    localparam int cycleLimit  = 4 * testCycles;

    logic                        clk;
    logic                        rstN;
    logic [ports-1:0]            inValid;
    routerPkg::flitT [ports-1:0] inFlit;
    logic [ports-1:0]            inFull;
    logic [ports-1:0]            outValid;
    routerPkg::flitT [ports-1:0] outFlit;

    integer seed = 32'h8b92c6e7;
    int cycleCount = 0;
    int errorCount = 0;
    int testErrors = 0;
    int testCount  = 0;
    int checkCount = 0;

    // Expected round-robin pointer of every output
    int rrModel [0:ports-1];
    // Flits accepted per source with the oldest first
    routerPkg::flitT expQ [0:ports-1][$];

    clockGen clkGen0 (
        .clk  (clk),
        .rstN (rstN)
    );

    meshRouter #(
        .routerX   (nodeX),
        .routerY   (nodeY),
        .fifoDepth (4)
    ) dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inFlit   (inFlit),
        .inFull   (inFull),
        .outValid (outValid),
        .outFlit  (outFlit)
    );

    bind meshRouter meshRouter_checker chk0 (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inFull   (inFull),
        .outValid (outValid),
        .outSel   (outSel),
        .reqValid ({reqBus[4].reqValid, reqBus[3].reqValid, reqBus[2].reqValid,
                    reqBus[1].reqValid, reqBus[0].reqValid}),
        .grant    ({reqBus[4].grant, reqBus[3].grant, reqBus[2].grant,
                    reqBus[1].grant, reqBus[0].grant})
    );

    // Hard stop for a hung run
    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Run stopped after %0d cycles, a test never finished", cycleCount);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Step to just past the next edge where outputs have settled
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkValue(input string sigName, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            $display("Fail %s: got %h, expected %h", sigName, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond)
        else
        begin
            $display("%s", what);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        errorCount += testErrors;
        $display("Test %0d %s finished with %0d errors", testCount, name, testErrors);
        testErrors = 0;
    endtask

    // Expected output by dimension order routing
    function automatic int routeTarget(input routerPkg::flitT f);
        if (f.destX > nodeX)
            return routerPkg::eastPort;
        if (f.destX < nodeX)
            return routerPkg::westPort;
        if (f.destY > nodeY)
            return routerPkg::northPort;
        if (f.destY < nodeY)
            return routerPkg::southPort;
        return routerPkg::localPort;
    endfunction

    // Random flit redrawn until it heads for the wanted output
    function automatic routerPkg::flitT flitFor(input int port);
        logic [31:0] r;
        routerPkg::flitT f;
        do
        begin
            r = $random(seed);
            f = r[$bits(routerPkg::flitT)-1:0];
        end
        while (routeTarget(f) != port);
        return f;
    endfunction

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic resetState();
        nextCycle();
        nextCycle();
        checkValue("outValid", outValid, 0);
        checkValue("inFull", inFull, 0);
        wait (rstN === 1'b1);
        nextCycle();
        checkValue("outValid", outValid, 0);
        checkValue("inFull", inFull, 0);
        finishTest("reset state");
    endtask

    // One flit per direction from the local input
    task automatic routeEachDirection();
        routerPkg::flitT f;
        for (int p = 0; p < ports; p++)
        begin
            f = flitFor(p);
            inFlit[localP]  = f;
            inValid[localP] = 1'b1;
            nextCycle();
            inValid = '0;
            checkValue("outValid", outValid, 0);
            nextCycle();
            checkValue("outValid", outValid, 1 << p);
            checkValue($sformatf("outFlit[%0d]", p), outFlit[p], f);
            rrModel[p] = (localP + 1) % ports;
            nextCycle();
            checkValue("outValid", outValid, 0);
        end
        finishTest("routing");
    endtask

    // Input i heads for output i+2 so every output is busy at once
    task automatic permuteAllInputs();
        routerPkg::flitT sent [0:ports-1];
        int dest;
        for (int i = 0; i < ports; i++)
        begin
            sent[i]   = flitFor((i + 2) % ports);
            inFlit[i] = sent[i];
        end
        inValid = '1;
        nextCycle();
        inValid = '0;
        nextCycle();
        checkValue("outValid", outValid, {ports{1'b1}});
        for (int i = 0; i < ports; i++)
        begin
            dest = (i + 2) % ports;
            checkValue($sformatf("outFlit[%0d]", dest), outFlit[dest], sent[i]);
            rrModel[dest] = (i + 1) % ports;
        end
        nextCycle();
        checkValue("outValid", outValid, 0);
        finishTest("parallel permutation");
    endtask

    // Several inputs share one output and are served in round-robin order
    task automatic contentionRound(input int target, input logic [ports-1:0] senders);
        routerPkg::flitT sent [0:ports-1];
        logic [ports-1:0] pending;
        int winner;
        for (int i = 0; i < ports; i++)
        begin
            sent[i] = flitFor(target);
            inFlit[i] = sent[i];
        end
        inValid = senders;
        nextCycle();
        inValid = '0;
        pending = senders;
        while (pending != '0)
        begin
            // First waiting input at or after the pointer
            winner = -1;
            for (int k = 0; k < ports; k++)
            begin
                if (winner < 0 && pending[(rrModel[target] + k) % ports])
                    winner = (rrModel[target] + k) % ports;
            end
            nextCycle();
            checkValue("outValid", outValid, 1 << target);
            checkValue($sformatf("outFlit[%0d]", target), outFlit[target], sent[winner]);
            pending[winner] = 1'b0;
            rrModel[target] = (winner + 1) % ports;
        end
        nextCycle();
        checkValue("outValid", outValid, 0);
    endtask

    task automatic contendForEast();
        logic [ports-1:0] senders;
        senders = '0;
        senders[routerPkg::northPort] = 1'b1;
        senders[routerPkg::southPort] = 1'b1;
        senders[routerPkg::westPort]  = 1'b1;
        contentionRound(routerPkg::eastPort, senders);
        // Pointer has moved past west
        contentionRound(routerPkg::eastPort, senders);
        finishTest("contention");
    endtask

    // Four inputs flood the local output and must back off on inFull
    task automatic floodLocalOutput();
        int sentCount [0:ports-1];
        int remaining;
        int src;
        logic sawFull;
        routerPkg::flitT f;
        sawFull = 1'b0;
        for (int s = 0; s < ports; s++)
            sentCount[s] = 0;
        do
        begin
            nextCycle();
            checkValue("outValid[4:1]", outValid[ports-1:1], 0);
            if (outValid[localP])
            begin
                // Source number and sequence ride in the payload
                src = outFlit[localP].data[7:5];
                checkTrue(src >= 1 && src < ports && expQ[src].size() > 0,
                          "local output delivered a flit that was never accepted");
                if (src >= 1 && src < ports && expQ[src].size() > 0)
                    checkValue("outFlit[0]", outFlit[localP], expQ[src].pop_front());
            end
            if (inFull != '0)
                sawFull = 1'b1;
            inValid = '0;
            for (int s = 1; s < ports; s++)
            begin
                if (!inFull[s] && sentCount[s] < burstLength)
                begin
                    f = flitFor(localP);
                    f.data = {3'(s), 5'(sentCount[s])};
                    inFlit[s]  = f;
                    inValid[s] = 1'b1;
                    expQ[s].push_back(f);
                    sentCount[s]++;
                end
            end
            remaining = 0;
            for (int s = 1; s < ports; s++)
                remaining += burstLength - sentCount[s] + expQ[s].size();
        end
        while (remaining > 0);
        checkTrue(sawFull, "inFull never went high while four inputs shared one output");
        nextCycle();
        checkValue("outValid", outValid, 0);
        finishTest("buffer full");
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial
    begin
        inValid = '0;
        inFlit  = '0;
        // Every pointer starts at input 0
        for (int o = 0; o < ports; o++)
            rrModel[o] = 0;
        resetState();
        routeEachDirection();
        permuteAllInputs();
        contendForEast();
        floodLocalOutput();
        $display("Tests run %0d, checks %0d, errors %0d, assertion failures %0d",
                 testCount, checkCount, errorCount, dut0.chk0.failCount);
        if (errorCount == 0 && dut0.chk0.failCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: src.f
routerPkg.sv
portRequestIf.sv
flitFifo.sv
inputPort.sv
switchAllocator.sv
crossbarSwitch.sv
meshRouter.sv
clockGen.sv
meshRouter_checker.sv
routerTb.sv

// File: switchAllocator.sv
`timescale 1ns/1ps

module switchAllocator (
    input  logic                                           clk,
    input  logic                                           rstN,
    portRequestIf.arbiter                                  reqs [0:routerPkg::portCount-1],
    output routerPkg::portSelT [routerPkg::portCount-1:0]  outSel
);

    localparam int ptrWidth = $clog2(routerPkg::portCount);

    // Flattened view of the request interfaces
    logic               reqValidV [0:routerPkg::portCount-1];
    routerPkg::portSelT reqPortV  [0:routerPkg::portCount-1];
    logic               grantV    [0:routerPkg::portCount-1];

    // Per output, which inputs want it
    logic [routerPkg::portCount-1:0] reqMatrix [0:routerPkg::portCount-1];

    // Round-robin state, one pointer per output
    logic [ptrWidth-1:0] rrPtr  [0:routerPkg::portCount-1];
    logic [ptrWidth-1:0] winIdx [0:routerPkg::portCount-1];
    logic                winValid [0:routerPkg::portCount-1];

    //////////////////////////////////////////////////
    // Interface unpacking
    //////////////////////////////////////////////////

    for (genvar i = 0; i < routerPkg::portCount; i++)
    begin : gUnpack
        assign reqValidV[i]  = reqs[i].reqValid;
        assign reqPortV[i]   = reqs[i].reqPort;
        assign reqs[i].grant = grantV[i];
    end

    // Transpose input requests into output columns
    always_comb
    begin
        for (int o = 0; o < routerPkg::portCount; o++)
        begin
            for (int i = 0; i < routerPkg::portCount; i++)
            begin
                reqMatrix[o][i] = reqValidV[i] & reqPortV[i][o];
            end
        end
    end

    //////////////////////////////////////////////////
    // Winner search
    //////////////////////////////////////////////////

    // First requester at or after the pointer, wrapping upward
    always_comb
    begin : pickWinner
        int cand;
        for (int o = 0; o < routerPkg::portCount; o++)
        begin
            winValid[o] = 1'b0;
            winIdx[o]   = '0;
            for (int k = 0; k < routerPkg::portCount; k++)
            begin
                cand = (int'(rrPtr[o]) + k) % routerPkg::portCount;
                if (!winValid[o] && reqMatrix[o][cand])
                begin
                    winValid[o] = 1'b1;
                    winIdx[o]   = ptrWidth'(cand);
                end
            end
            // One-hot select, zero when idle
            outSel[o] = '0;
            if (winValid[o])
                outSel[o][winIdx[o]] = 1'b1;
        end
    end

    // Each input targets one output, so at most one column grants it
    always_comb
    begin
        for (int i = 0; i < routerPkg::portCount; i++)
        begin
            grantV[i] = 1'b0;
            for (int o = 0; o < routerPkg::portCount; o++)
            begin
                grantV[i] = grantV[i] | outSel[o][i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Pointer update
    //////////////////////////////////////////////////

    // Move to one past the winner after every grant
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int o = 0; o < routerPkg::portCount; o++)
                rrPtr[o] <= '0;
        end
        else
        begin
            for (int o = 0; o < routerPkg::portCount; o++)
            begin
                if (winValid[o])
                begin
                    if (winIdx[o] == ptrWidth'(routerPkg::portCount - 1))
                        rrPtr[o] <= '0;
                    else
                        rrPtr[o] <= winIdx[o] + 1'b1;
                end
            end
        end
    end

endmodule
